/* verilog/gpu_config.svh */
`ifndef GPU_CONFIG_SVH
`define GPU_CONFIG_SVH

`define GPU_WIDTH        64          // screen width
`define GPU_HEIGHT       64          // screen height
`define GPU_COORD_BITS   8
`define GPU_COLOR_BITS   12          // 4 bits per channel
`define GPU_FB_BASE      16'h4000    // frame-buffer read window

`define GPU_REG_CTRL     16'h0000
`define GPU_REG_STATUS   16'h0004
`define GPU_REG_CENTER   16'h0008
`define GPU_REG_RADIUS   16'h000C
`define GPU_REG_COLOR    16'h0010
`define GPU_REG_PIXCNT   16'h0014

`endif

/* verilog/gpu_pkg.sv */
`default_nettype none

`include "gpu_config.svh"

package gpu_pkg;

  typedef logic [`GPU_COORD_BITS-1:0] coord_t;
  typedef logic signed [`GPU_COORD_BITS+1:0] scoord_t;    // chord ends before clipping
  typedef logic [`GPU_COLOR_BITS-1:0] color_t;
  typedef logic [$clog2(`GPU_WIDTH * `GPU_HEIGHT)-1:0] fbAddr_t;   // y * width + x
  typedef logic [15:0] pixCount_t;

  typedef enum logic [2:0]
  {
    IDLE,
    CHORD_TOP,      // row yc+y
    CHORD_UPPER,    // row yc+x
    CHORD_BOTTOM,   // row yc-y
    CHORD_LOWER,    // row yc-x
    STEP,
    FINISH
  } chordState_t;

endpackage

`default_nettype wire

/* verilog/pixel_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface pixel_if;

  logic              valid;
  logic              ready;
  gpu_pkg::coord_t   x;
  gpu_pkg::coord_t   y;
  gpu_pkg::color_t   color;

  // source holds x, y and color while stalled
  modport source (output valid, output x, output y, output color, input ready);

  modport sink (input valid, input x, input y, input color, output ready);

endinterface

`default_nettype wire

/* verilog/apbCircleRegs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gpu_config.svh"

module apbCircleRegs
(
  input  wire                    clk,
  input  wire                    n_rst,
  input  wire [15:0]             paddr_i,
  input  wire                    psel_i,
  input  wire                    penable_i,
  input  wire                    pwrite_i,
  input  wire [31:0]             pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  input  wire                    rastBusy_i,
  input  wire                    rastDone_i,
  input  wire                    pixelWritten_i,
  output gpu_pkg::coord_t        centerX_o,
  output gpu_pkg::coord_t        centerY_o,
  output gpu_pkg::coord_t        radius_o,
  output gpu_pkg::color_t        color_o,
  output logic                   startPulse_o,
  output gpu_pkg::fbAddr_t       fbRdAddr_o,
  output logic                   fbRdEn_o,
  input  wire gpu_pkg::color_t   fbRdData_i,
  output logic                   irq_o
);

  logic                 access;
  logic [15:0]          fbOffset;
  logic                 isFb;
  logic                 isCtrl;
  logic                 isStatus;
  logic                 isCenter;
  logic                 isRadius;
  logic                 isColor;
  logic                 isPixCnt;
  logic                 regHit;
  logic                 isCfg;
  logic                 slvErr;
  logic                 wrEn;
  logic                 startWr;
  logic                 fbWait;       // second cycle of a frame-buffer read
  logic                 doneFlag;
  gpu_pkg::pixCount_t   pixCnt;

  // ################################################
  // address decode
  assign access   = psel_i & penable_i;
  assign isCtrl   = (paddr_i == `GPU_REG_CTRL);
  assign isStatus = (paddr_i == `GPU_REG_STATUS);
  assign isCenter = (paddr_i == `GPU_REG_CENTER);
  assign isRadius = (paddr_i == `GPU_REG_RADIUS);
  assign isColor  = (paddr_i == `GPU_REG_COLOR);
  assign isPixCnt = (paddr_i == `GPU_REG_PIXCNT);

  assign fbOffset = paddr_i - `GPU_FB_BASE;
  assign isFb     = (paddr_i >= `GPU_FB_BASE) &&
                    (fbOffset < 16'(`GPU_WIDTH * `GPU_HEIGHT * 4));   // one word per pixel

  assign regHit   = isCtrl | isStatus | isCenter | isRadius | isColor | isPixCnt;
  assign isCfg    = isCenter | isRadius | isColor;

  assign slvErr   = ~(regHit | isFb)
                  | (pwrite_i & isFb)                          // window is read only
                  | (pwrite_i & isCtrl & pwdata_i[0] & rastBusy_i)
                  | (pwrite_i & isCfg & rastBusy_i);           // job locked while drawing

  // ################################################
  // handshake, frame-buffer reads take one wait state
  assign fbRdEn_o   = access & ~pwrite_i & isFb & ~fbWait;
  assign fbRdAddr_o = gpu_pkg::fbAddr_t'(fbOffset >> 2);
  assign pready_o   = access & (~(isFb & ~pwrite_i) | fbWait);
  assign pslverr_o  = pready_o & slvErr;

  assign wrEn    = access & pwrite_i & ~slvErr;   // writes never wait
  assign startWr = wrEn & isCtrl & pwdata_i[0];
  assign irq_o   = doneFlag;

  always_comb
  begin
    prdata_o = '0;
    if (isStatus)
      prdata_o = {30'b0, rastBusy_i, doneFlag};
    else if (isCenter)
    begin
      prdata_o[0 +: `GPU_COORD_BITS]  = centerX_o;
      prdata_o[16 +: `GPU_COORD_BITS] = centerY_o;
    end
    else if (isRadius)
      prdata_o[0 +: `GPU_COORD_BITS] = radius_o;
    else if (isColor)
      prdata_o[0 +: `GPU_COLOR_BITS] = color_o;
    else if (isPixCnt)
      prdata_o = 32'(pixCnt);
    else if (isFb)
      prdata_o[0 +: `GPU_COLOR_BITS] = fbRdData_i;   // registered memory data
  end

  // ################################################
  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      fbWait       <= 1'b0;
      startPulse_o <= 1'b0;
      doneFlag     <= 1'b0;
      pixCnt       <= '0;
      centerX_o    <= '0;
      centerY_o    <= '0;
      radius_o     <= '0;
      color_o      <= '0;
    end
    else
    begin
      fbWait       <= fbRdEn_o;
      startPulse_o <= startWr;

      if (wrEn && isCenter)
      begin
        centerX_o <= pwdata_i[0 +: `GPU_COORD_BITS];
        centerY_o <= pwdata_i[16 +: `GPU_COORD_BITS];
      end
      if (wrEn && isRadius)
        radius_o <= pwdata_i[0 +: `GPU_COORD_BITS];
      if (wrEn && isColor)
        color_o <= pwdata_i[0 +: `GPU_COLOR_BITS];

      if (startWr)
        doneFlag <= 1'b0;
      else if (rastDone_i)
        doneFlag <= 1'b1;             // sticky until next start

      if (startWr)
        pixCnt <= '0;
      else if (pixelWritten_i)
        pixCnt <= pixCnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/circleRasterizer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gpu_config.svh"

module circleRasterizer
(
  input  wire                    clk,
  input  wire                    n_rst,
  input  wire gpu_pkg::coord_t   centerX_i,
  input  wire gpu_pkg::coord_t   centerY_i,
  input  wire gpu_pkg::coord_t   radius_i,
  input  wire gpu_pkg::color_t   color_i,
  input  wire                    start_i,
  output logic                   busy_o,
  output logic                   done_o,
  pixel_if.source                pix
);

  gpu_pkg::chordState_t   state;
  gpu_pkg::chordState_t   chordNext;
  gpu_pkg::coord_t        stepX;
  gpu_pkg::coord_t        stepY;
  gpu_pkg::coord_t        walkOff;      // offset from the left chord end
  logic signed [11:0]     dVar;         // midpoint decision variable
  logic signed [11:0]     twoX;
  logic signed [11:0]     twoY;
  gpu_pkg::scoord_t       cx;
  gpu_pkg::scoord_t       cy;
  gpu_pkg::scoord_t       sx;
  gpu_pkg::scoord_t       sy;
  gpu_pkg::scoord_t       rowS;
  gpu_pkg::scoord_t       loS;
  gpu_pkg::scoord_t       hiS;
  gpu_pkg::scoord_t       clipLo;
  gpu_pkg::scoord_t       clipHi;
  gpu_pkg::scoord_t       curX;
  logic                   inChord;
  logic                   chordOk;
  logic                   lastPix;
  logic                   fire;

  function automatic gpu_pkg::scoord_t clampS(input gpu_pkg::scoord_t v, input int lim);
    if (v < 0)
      return '0;
    if (v > lim)
      return gpu_pkg::scoord_t'(lim);
    return v;
  endfunction

  assign cx   = gpu_pkg::scoord_t'(centerX_i);
  assign cy   = gpu_pkg::scoord_t'(centerY_i);
  assign sx   = gpu_pkg::scoord_t'(stepX);
  assign sy   = gpu_pkg::scoord_t'(stepY);
  assign twoX = $signed(12'({stepX, 1'b0}));
  assign twoY = $signed(12'({stepY, 1'b0}));

  // ################################################
  // chord endpoints for the current step
  always_comb
  begin
    rowS      = cy;
    loS       = cx;
    hiS       = cx;
    chordNext = gpu_pkg::IDLE;
    case (state)
      gpu_pkg::CHORD_TOP:
      begin
        rowS      = cy + sy;
        loS       = cx - sx;
        hiS       = cx + sx;
        chordNext = gpu_pkg::CHORD_UPPER;
      end
      gpu_pkg::CHORD_UPPER:
      begin
        rowS      = cy + sx;
        loS       = cx - sy;
        hiS       = cx + sy;
        chordNext = gpu_pkg::CHORD_BOTTOM;
      end
      gpu_pkg::CHORD_BOTTOM:
      begin
        rowS      = cy - sy;
        loS       = cx - sx;
        hiS       = cx + sx;
        chordNext = gpu_pkg::CHORD_LOWER;
      end
      gpu_pkg::CHORD_LOWER:
      begin
        rowS      = cy - sx;
        loS       = cx - sy;
        hiS       = cx + sy;
        chordNext = gpu_pkg::STEP;
      end
      default:
      begin
        chordNext = gpu_pkg::IDLE;
      end
    endcase
  end

  assign inChord = (state == gpu_pkg::CHORD_TOP) || (state == gpu_pkg::CHORD_UPPER) ||
                   (state == gpu_pkg::CHORD_BOTTOM) || (state == gpu_pkg::CHORD_LOWER);

  // clip to the screen, empty chords are skipped
  assign clipLo  = clampS(loS, `GPU_WIDTH - 1);
  assign clipHi  = clampS(hiS, `GPU_WIDTH - 1);
  assign chordOk = inChord && (rowS >= 0) && (rowS <= `GPU_HEIGHT - 1) && (clipLo <= clipHi);

  assign curX    = clipLo + gpu_pkg::scoord_t'(walkOff);
  assign lastPix = (curX >= clipHi);

  assign pix.valid = chordOk;
  assign pix.x     = gpu_pkg::coord_t'(curX);
  assign pix.y     = gpu_pkg::coord_t'(rowS);
  assign pix.color = color_i;               // colour passes straight through
  assign fire      = pix.valid & pix.ready;

  assign busy_o = (state != gpu_pkg::IDLE);
  assign done_o = (state == gpu_pkg::FINISH);

  // ################################################
  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
    begin
      state   <= gpu_pkg::IDLE;
      stepX   <= '0;
      stepY   <= '0;
      dVar    <= '0;
      walkOff <= '0;
    end
    else
    begin
      case (state)
        gpu_pkg::IDLE:
        begin
          if (start_i)
          begin
            stepX   <= '0;
            stepY   <= radius_i;
            dVar    <= 12'sd1 - $signed(12'(radius_i));
            walkOff <= '0;
            state   <= gpu_pkg::CHORD_TOP;
          end
        end
        gpu_pkg::CHORD_TOP, gpu_pkg::CHORD_UPPER, gpu_pkg::CHORD_BOTTOM, gpu_pkg::CHORD_LOWER:
        begin
          if (!chordOk || (fire && lastPix))
          begin
            walkOff <= '0;
            state   <= chordNext;
          end
          else if (fire)
            walkOff <= walkOff + 1'b1;   // stalls while ready is low
        end
        gpu_pkg::STEP:
        begin
          if (stepX >= stepY)
            state <= gpu_pkg::FINISH;
          else
          begin
            if (dVar < 0)
              dVar <= dVar + twoX + 12'sd3;
            else
            begin
              dVar  <= dVar + twoX - twoY + 12'sd5;
              stepY <= stepY - 1'b1;
            end
            stepX <= stepX + 1'b1;
            state <= gpu_pkg::CHORD_TOP;
          end
        end
        gpu_pkg::FINISH:
          state <= gpu_pkg::IDLE;        // one cycle done pulse
        default:
          state <= gpu_pkg::IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/frameBuffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gpu_config.svh"

module frameBuffer
(
  input  wire                    clk,
  input  wire                    n_rst,
  pixel_if.sink                  pix,
  input  wire                    rdEn_i,
  input  wire gpu_pkg::fbAddr_t  rdAddr_i,
  output gpu_pkg::color_t        rdData_o,
  output logic                   pixelWritten_o
);

  gpu_pkg::color_t    mem [`GPU_WIDTH * `GPU_HEIGHT];
  gpu_pkg::fbAddr_t   wrAddr;
  logic               wrFire;

  // single port, a read takes the cycle
  assign pix.ready = ~rdEn_i;
  assign wrFire    = pix.valid & pix.ready;
  assign wrAddr    = gpu_pkg::fbAddr_t'(pix.y * `GPU_WIDTH + pix.x);

  always_ff @(posedge clk)
  begin
    if (wrFire)
      mem[wrAddr] <= pix.color;
    if (rdEn_i)
      rdData_o <= mem[rdAddr_i];     // valid on the next cycle
  end

  // ################################################
  // strobe for the pixel counter
  always_ff @(posedge clk or negedge n_rst)
  begin
    if (!n_rst)
      pixelWritten_o <= 1'b0;
    else
      pixelWritten_o <= wrFire;
  end

endmodule

`default_nettype wire

/* verilog/circleGpu.sv */
`timescale 1ns/1ns
`default_nettype none

module circleGpu
(
  input  wire          clk,
  input  wire          n_rst,
  input  wire [15:0]   paddr_i,
  input  wire          psel_i,
  input  wire          penable_i,
  input  wire          pwrite_i,
  input  wire [31:0]   pwdata_i,
  output wire [31:0]   prdata_o,
  output wire          pready_o,
  output wire          pslverr_o,
  output wire          irq_o
);

  wire gpu_pkg::coord_t    centerX;
  wire gpu_pkg::coord_t    centerY;
  wire gpu_pkg::coord_t    radius;
  wire gpu_pkg::color_t    color;
  wire gpu_pkg::fbAddr_t   fbRdAddr;
  wire gpu_pkg::color_t    fbRdData;
  wire                     fbRdEn;
  wire                     startPulse;
  wire                     rastBusy;
  wire                     donePulse;
  wire                     pixelWritten;

  pixel_if pixBus ();       // rasteriser to frame buffer

  apbCircleRegs u_regs
  (
    .clk            (clk),
    .n_rst          (n_rst),
    .paddr_i        (paddr_i),
    .psel_i         (psel_i),
    .penable_i      (penable_i),
    .pwrite_i       (pwrite_i),
    .pwdata_i       (pwdata_i),
    .prdata_o       (prdata_o),
    .pready_o       (pready_o),
    .pslverr_o      (pslverr_o),
    .rastBusy_i     (rastBusy),
    .rastDone_i     (donePulse),
    .pixelWritten_i (pixelWritten),
    .centerX_o      (centerX),
    .centerY_o      (centerY),
    .radius_o       (radius),
    .color_o        (color),
    .startPulse_o   (startPulse),
    .fbRdAddr_o     (fbRdAddr),
    .fbRdEn_o       (fbRdEn),
    .fbRdData_i     (fbRdData),
    .irq_o          (irq_o)
  );

  circleRasterizer u_rast
  (
    .clk        (clk),
    .n_rst      (n_rst),
    .centerX_i  (centerX),
    .centerY_i  (centerY),
    .radius_i   (radius),
    .color_i    (color),
    .start_i    (startPulse),
    .busy_o     (rastBusy),
    .done_o     (donePulse),
    .pix        (pixBus.source)
  );

  frameBuffer u_fb
  (
    .clk            (clk),
    .n_rst          (n_rst),
    .pix            (pixBus.sink),
    .rdEn_i         (fbRdEn),
    .rdAddr_i       (fbRdAddr),
    .rdData_o       (fbRdData),
    .pixelWritten_o (pixelWritten)
  );

endmodule

`default_nettype wire

/* verif/circleGpu_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module circleGpu_properties
(
  input wire                    clk,
  input wire                    n_rst,
  input wire                    psel_i,
  input wire                    penable_i,
  input wire                    pready_i,
  input wire                    pslverr_i,
  input wire                    busy_i,
  input wire                    pixValid_i,
  input wire                    pixReady_i,
  input wire gpu_pkg::coord_t   pixX_i,
  input wire gpu_pkg::coord_t   pixY_i,
  input wire gpu_pkg::color_t   pixColor_i
);

  int failCount = 0;      // failed assertion count

  // ################################################
  // APB slave side
  readyInAccess: assert property (@(posedge clk) disable iff (!n_rst)
    pready_i |-> (psel_i && penable_i))
  else
  begin
    failCount++;
    $error("PREADY raised outside the ACCESS phase");
  end

  errWithReady: assert property (@(posedge clk) disable iff (!n_rst)
    pslverr_i |-> pready_i)
  else
  begin
    failCount++;
    $error("PSLVERR raised without PREADY");
  end

  // ################################################
  // pixel stream
  holdWhileStalled: assert property (@(posedge clk) disable iff (!n_rst)
    (pixValid_i && !pixReady_i) |=>
      (pixValid_i && $stable(pixX_i) && $stable(pixY_i) && $stable(pixColor_i)))
  else
  begin
    failCount++;
    $error("pixel changed while stalled");
  end

  idleNoPixel: assert property (@(posedge clk) disable iff (!n_rst)
    !busy_i |-> !pixValid_i)
  else
  begin
    failCount++;
    $error("pixel valid while the rasteriser is idle");
  end

endmodule

`default_nettype wire

/* verif/circleGpu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "gpu_config.svh"

module circleGpu_tb;

  localparam int APB_TIMEOUT  = 20;
  localparam int DONE_TIMEOUT = 4000;     // status polls
  localparam int FB_WORDS     = `GPU_WIDTH * `GPU_HEIGHT;

  logic          clk;
  logic          n_rst;
  logic [15:0]   paddr;
  logic          psel;
  logic          penable;
  logic          pwrite;
  logic [31:0]   pwdata;
  wire  [31:0]   prdata;
  wire           pready;
  wire           pslverr;
  wire           irq;

  logic [39:0]   testData [0:63];
  logic [11:0]   shadow [0:FB_WORDS-1];     // reference frame buffer
  bit            written [0:FB_WORDS-1];
  bit            lastCover [0:FB_WORDS-1];  // pixels of the latest job
  logic [15:0]   lfsrState;
  int            modelCount;
  int            lastXc;
  int            lastYc;
  int            lastR;
  int            checkCount;
  int            errorCount;
  int            testCount;
  int            failedTests;
  bit            timedOut;

  circleGpu u_dut
  (
    .clk       (clk),
    .n_rst     (n_rst),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr),
    .irq_o     (irq)
  );

  bind circleGpu circleGpu_properties u_props
  (
    .clk        (clk),
    .n_rst      (n_rst),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pready_i   (pready_o),
    .pslverr_i  (pslverr_o),
    .busy_i     (rastBusy),
    .pixValid_i (pixBus.valid),
    .pixReady_i (pixBus.ready),
    .pixX_i     (pixBus.x),
    .pixY_i     (pixBus.y),
    .pixColor_i (pixBus.color)
  );

  always #10 clk = ~clk;

  // ################################################
  // checks, random numbers, APB
  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("Error %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);   // x^16+x^14+x^13+x^11+1
  endfunction

  task automatic randomBits(input int n, output int v);
    v = 0;
    for (int k = 0; k < n; k++)
    begin
      v = (v << 1) | lfsrState[0];
      lfsrState = lfsrNext(lfsrState);
    end
  endtask

  task automatic reportTimeout(input string what);
    errorCount++;
    $display("Timeout: %s", what);
    timedOut = 1'b1;
    @(posedge clk);       // main process is stopped here
  endtask

  task automatic apbTransfer(input logic write, input logic [15:0] addr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output logic err);
    int waits;
    waits = 0;
    @(posedge clk);
    paddr   <= addr;
    pwrite  <= write;
    pwdata  <= wdata;
    psel    <= 1'b1;
    penable <= 1'b0;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    while (!pready && waits < APB_TIMEOUT)
    begin
      waits++;
      @(negedge clk);
    end
    if (!pready)
      reportTimeout("APB transfer never got PREADY");
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apbWrite(input logic [15:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apbTransfer(1'b1, addr, data, unused, err);
  endtask

  task automatic apbRead(input logic [15:0] addr, output logic [31:0] data, output logic err);
    apbTransfer(1'b0, addr, 32'h0, data, err);
  endtask

  // ################################################
  // reference model of the drawing rule
  function automatic int clampCoord(input int v);
    if (v < 0)
      return 0;
    if (v > `GPU_WIDTH - 1)
      return `GPU_WIDTH - 1;
    return v;
  endfunction

  task automatic drawChord(input int row, input int lo, input int hi, input logic [11:0] col);
    int a;
    int b;
    if (row < 0 || row > `GPU_HEIGHT - 1)
      return;
    a = clampCoord(lo);
    b = clampCoord(hi);
    for (int x = a; x <= b; x++)
    begin
      shadow[row * `GPU_WIDTH + x]    = col;
      written[row * `GPU_WIDTH + x]   = 1'b1;
      lastCover[row * `GPU_WIDTH + x] = 1'b1;
      modelCount++;           // repeats count too
    end
  endtask

  task automatic drawModel(input int xc, input int yc, input int r, input logic [11:0] col);
    int x;
    int y;
    int d;
    x = 0;
    y = r;
    d = 1 - r;
    modelCount = 0;
    lastXc = xc;
    lastYc = yc;
    lastR = r;
    foreach (lastCover[k])
      lastCover[k] = 1'b0;
    forever
    begin
      drawChord(yc + y, xc - x, xc + x, col);
      drawChord(yc + x, xc - y, xc + y, col);
      drawChord(yc - y, xc - x, xc + x, col);
      drawChord(yc - x, xc - y, xc + y, col);
      if (x >= y)
        break;
      if (d < 0)
        d = d + 2 * x + 3;
      else
      begin
        d = d + 2 * (x - y) + 5;
        y = y - 1;
      end
      x = x + 1;
    end
  endtask

  // ################################################
  // test steps
  task automatic probePixel(input string name, input int x, input int y);
    logic [31:0] data;
    logic err;
    int idx;
    if (x < 0 || x > `GPU_WIDTH - 1 || y < 0 || y > `GPU_HEIGHT - 1)
      return;
    idx = y * `GPU_WIDTH + x;
    apbRead(16'(`GPU_FB_BASE + idx * 4), data, err);
    checkValue(name, 32'h0, {31'b0, err});
    if (written[idx])
      checkValue(name, {20'b0, shadow[idx]}, data);
  endtask

  task automatic randomProbes(input string name, input int n);
    int rx;
    int ry;
    int span;
    span = 2 * lastR + 1;     // bounding box of the last job
    for (int k = 0; k < n; k++)
    begin
      randomBits(8, rx);
      randomBits(8, ry);
      probePixel(name, lastXc - lastR + rx % span, lastYc - lastR + ry % span);
    end
  endtask

  task automatic waitDone(input string name);
    logic [31:0] status;
    logic err;
    int polls;
    polls = 0;
    apbRead(`GPU_REG_STATUS, status, err);
    while (!status[0] && polls < DONE_TIMEOUT)
    begin
      polls++;
      apbRead(`GPU_REG_STATUS, status, err);
    end
    if (!status[0])
      reportTimeout("STATUS.done was never set");
    checkValue(name, 32'h1, status);     // done and idle
    checkValue(name, 32'h1, {31'b0, irq});
  endtask

  task automatic runJob(input string name, input logic [39:0] rec);
    logic [31:0] data;
    logic err;
    int idx;
    apbWrite(`GPU_REG_CENTER, {8'h0, rec[27:20], 8'h0, rec[35:28]}, err);
    checkValue(name, 32'h0, {31'b0, err});
    apbWrite(`GPU_REG_RADIUS, {24'h0, rec[19:12]}, err);
    checkValue(name, 32'h0, {31'b0, err});
    apbWrite(`GPU_REG_COLOR, {20'h0, rec[11:0]}, err);
    checkValue(name, 32'h0, {31'b0, err});
    apbWrite(`GPU_REG_CTRL, 32'h1, err);
    checkValue(name, 32'h0, {31'b0, err});
    drawModel(rec[35:28], rec[27:20], rec[19:12], rec[11:0]);
    if (rec[39:36] == 4'd3)
    begin
      apbRead(`GPU_REG_STATUS, data, err);
      checkValue(name, 32'h2, data);           // busy, done cleared
      apbWrite(`GPU_REG_CTRL, 32'h1, err);
      checkValue(name, 32'h1, {31'b0, err});
      apbWrite(`GPU_REG_CENTER, 32'h0, err);
      checkValue(name, 32'h1, {31'b0, err});
      apbWrite(`GPU_REG_RADIUS, 32'h3, err);
      checkValue(name, 32'h1, {31'b0, err});
      apbWrite(`GPU_REG_COLOR, 32'h0, err);
      checkValue(name, 32'h1, {31'b0, err});
      apbRead(`GPU_REG_RADIUS, data, err);
      checkValue(name, {24'h0, rec[19:12]}, data);
    end
    if (rec[39:36] == 4'd4)
    begin
      idx = -1;
      for (int k = FB_WORDS - 1; k >= 0; k--)
      begin
        if (written[k] && !lastCover[k])
          idx = k;                               // untouched by this job
      end
      if (idx >= 0)
        repeat (8) probePixel(name, idx % `GPU_WIDTH, idx / `GPU_WIDTH);
    end
    waitDone(name);
    apbRead(`GPU_REG_PIXCNT, data, err);
    checkValue(name, modelCount, data);
  endtask

  task automatic endTest(input string name, input int startErrors);
    testCount++;
    if (errorCount == startErrors)
      $display("%s: ok", name);
    else
    begin
      failedTests++;
      $display("%s: failed", name);
    end
  endtask

  function automatic string kindName(input logic [3:0] kind);
    case (kind)
      4'd1:    return "onscreen";
      4'd2:    return "clipped";
      4'd3:    return "busy";
      4'd4:    return "backpressure";
      4'd6:    return "probe";
      4'd7:    return "random";
      default: return "unknown";
    endcase
  endfunction

  task automatic runTests();
    logic [31:0] data;
    logic err;
    logic [39:0] rec;
    string name;
    int startErrors;
    startErrors = errorCount;
    checkValue("reset", 32'h0, {29'b0, pready, pslverr, irq});
    apbRead(`GPU_REG_STATUS, data, err);
    checkValue("reset", 32'h0, data);
    apbRead(`GPU_REG_PIXCNT, data, err);
    checkValue("reset", 32'h0, data);
    endTest("reset", startErrors);

    startErrors = errorCount;
    apbRead(16'h0100, data, err);
    checkValue("addr_error", 32'h1, {31'b0, err});
    apbWrite(`GPU_FB_BASE + 16'h0010, 32'h123, err);
    checkValue("addr_error", 32'h1, {31'b0, err});
    endTest("addr_error", startErrors);

    for (int i = 0; i < 64; i++)
    begin
      rec = testData[i];
      if ($isunknown(rec) || rec[39:36] == 4'd0)
        break;
      startErrors = errorCount;
      name = $sformatf("%s_%0d", kindName(rec[39:36]), i);
      if (rec[39:36] >= 4'd1 && rec[39:36] <= 4'd4)
        runJob(name, rec);
      else if (rec[39:36] == 4'd6)
        probePixel(name, rec[35:28], rec[27:20]);
      else if (rec[39:36] == 4'd7)
        randomProbes(name, rec[19:12]);
      else
      begin
        errorCount++;
        $display("data record %0d has an unknown kind", i);
      end
      endTest(name, startErrors);
    end
  endtask

  // ################################################
  initial
  begin
    clk = 1'b0;
    n_rst = 1'b0;
    paddr = '0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    pwdata = '0;
    lfsrState = 16'd60889;
    checkCount = 0;
    errorCount = 0;
    testCount = 0;
    failedTests = 0;
    timedOut = 1'b0;
    $readmemh("verif/circleGpu_testdata.txt", testData);
    repeat (16) @(posedge clk);
    n_rst <= 1'b1;
    fork
      runTests();
      wait (timedOut);
    join_any
    disable fork;
    errorCount += u_dut.u_props.failCount;    // bound assertion failures
    $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
             testCount, failedTests, checkCount, errorCount);
    if (errorCount == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* circleGpu.f */
+incdir+verilog
verilog/gpu_pkg.sv
verilog/pixel_if.sv
verilog/apbCircleRegs.sv
verilog/circleRasterizer.sv
verilog/frameBuffer.sv
verilog/circleGpu.sv
verif/circleGpu_properties.sv
verif/circleGpu_tb.sv

/* Bender.yml */
package:
  name: circleGpu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/gpu_pkg.sv
      - verilog/pixel_if.sv
      - verilog/apbCircleRegs.sv
      - verilog/circleRasterizer.sv
      - verilog/frameBuffer.sv
      - verilog/circleGpu.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/circleGpu_properties.sv
      - verif/circleGpu_tb.sv

/* verif/circleGpu_testdata.txt */
// one record per line, hex fields kind_a_b_c_colour
// kind 1 on-screen job, 2 clipped job, 3 job with writes while busy, 4 job with reads
// while drawing (a = xc, b = yc, c = radius); 6 probe at x = a, y = b; 7 c random probes
1_20_20_08_F00   // centre 32,32 r 8
6_20_20_00_000
6_28_20_00_000   // right end of row 32
6_20_18_00_000   // top pixel
7_00_00_08_000
1_26_22_06_0F0   // overlaps the first circle
6_26_22_00_000
6_22_21_00_000   // overlap, last writer wins
6_1A_20_00_000
7_00_00_08_000
2_02_3C_0A_00F   // left and bottom edges
6_00_3C_00_000   // clamped left end
6_0C_3C_00_000
6_00_3F_00_000   // bottom row
7_00_00_08_000
2_3E_01_0C_FFF   // right and top edges
6_3F_01_00_000
6_3F_00_00_000
6_32_01_00_000
7_00_00_06_000
3_10_30_0A_A5A   // busy protection
6_10_30_00_000
6_06_30_00_000
7_00_00_06_000
4_2C_0C_0C_5A5   // back-pressure
6_2C_0C_00_000
7_00_00_06_000
0_00_00_00_000
